/* Bender.yml */
package:
  name: chip8_core

sources:
  - files:
      - design/chip8_pkg.sv
      - design/program_ram.sv
      - design/v_regfile.sv
      - design/alu_8xy.sv
      - design/sequencer.sv
      - design/trace_credit.sv
      - design/chip8_core.sv
  - target: test
    files:
      - testbench/tb_chip8.sv

/* all.f */
design/chip8_pkg.sv
design/program_ram.sv
design/v_regfile.sv
design/alu_8xy.sv
design/sequencer.sv
design/trace_credit.sv
design/chip8_core.sv
testbench/tb_chip8.sv

/* design/alu_8xy.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_8xy
   import chip8_pkg::*;
(
   input  alu_op_e               op_i,
   input  logic [DATA_WIDTH-1:0] vx_i,
   input  logic [DATA_WIDTH-1:0] vy_i,
   output logic [DATA_WIDTH-1:0] result_o,
   output logic                  flag_o
);

   logic [DATA_WIDTH:0] sum;

   assign sum = {1'b0, vx_i} + {1'b0, vy_i};

   always_comb
   begin
      result_o = vy_i;
      flag_o   = 1'b0;
      case (op_i)
         MOV:  result_o = vy_i;
         OR:   result_o = vx_i | vy_i;
         AND:  result_o = vx_i & vy_i;
         XOR:  result_o = vx_i ^ vy_i;
         ADD:
         begin
            result_o = sum[DATA_WIDTH-1:0];
            flag_o   = sum[DATA_WIDTH]; // carry out
         end
         SUB:
         begin
            result_o = vx_i - vy_i;
            flag_o   = (vx_i > vy_i); // strict, not borrow
         end
         SUBN:
         begin
            result_o = vy_i - vx_i;
            flag_o   = (vy_i > vx_i);
         end
         SHR:
         begin
            result_o = vy_i >> 1;
            flag_o   = vy_i[0];
         end
         SHL:
         begin
            result_o = vy_i << 1;
            flag_o   = vy_i[DATA_WIDTH-1];
         end
         default:
         begin
            result_o = vy_i;
            flag_o   = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* design/chip8_core.sv */
`timescale 1ns/1ps
`default_nettype none

module chip8_core
   import chip8_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  run_i,
   input  logic                  load_we_i,
   input  logic [ADDR_WIDTH-1:0] load_addr_i,
   input  logic [DATA_WIDTH-1:0] load_data_i,
   input  logic                  trace_credit_i,
   output logic                  trace_valid_o,
   output logic [VREG_AW-1:0]    trace_reg_o,
   output logic [DATA_WIDTH-1:0] trace_data_o,
   output logic                  halted_o
);

   logic [ADDR_WIDTH-1:0] mem_addr;
   logic [DATA_WIDTH-1:0] mem_data;
   logic [VREG_AW-1:0]    raddr_x;
   logic [VREG_AW-1:0]    raddr_y;
   logic [DATA_WIDTH-1:0] vx_q;
   logic [DATA_WIDTH-1:0] vy_q;
   logic                  reg_we;
   logic [VREG_AW-1:0]    reg_waddr;
   logic [DATA_WIDTH-1:0] reg_wdata;
   alu_op_e               alu_op;
   logic [DATA_WIDTH-1:0] alu_result;
   logic                  alu_flag;
   logic                  credit_avail;
   logic                  trace_push;

   program_ram u_program_ram (
      .clk         (clk),
      .load_we_i   (load_we_i),
      .load_addr_i (load_addr_i),
      .load_data_i (load_data_i),
      .rd_addr_i   (mem_addr),
      .rd_data_o   (mem_data)
   );

   v_regfile u_v_regfile (
      .clk       (clk),
      .we_i      (reg_we),
      .waddr_i   (reg_waddr),
      .wdata_i   (reg_wdata),
      .raddr_x_i (raddr_x),
      .raddr_y_i (raddr_y),
      .vx_q_o    (vx_q),
      .vy_q_o    (vy_q)
   );

   alu_8xy u_alu_8xy (
      .op_i     (alu_op),
      .vx_i     (vx_q),
      .vy_i     (vy_q),
      .result_o (alu_result),
      .flag_o   (alu_flag)
   );

   sequencer u_sequencer (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .run_i          (run_i),
      .mem_addr_o     (mem_addr),
      .mem_data_i     (mem_data),
      .vx_q_i         (vx_q),
      .vy_q_i         (vy_q),
      .raddr_x_o      (raddr_x),
      .raddr_y_o      (raddr_y),
      .reg_we_o       (reg_we),
      .reg_waddr_o    (reg_waddr),
      .reg_wdata_o    (reg_wdata),
      .alu_op_o       (alu_op),
      .alu_result_i   (alu_result),
      .alu_flag_i     (alu_flag),
      .credit_avail_i (credit_avail),
      .push_o         (trace_push),
      .halted_o       (halted_o)
   );

   trace_credit u_trace_credit (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .push_i         (trace_push),
      .push_reg_i     (reg_waddr), // same beat as the regfile write
      .push_data_i    (reg_wdata),
      .trace_credit_i (trace_credit_i),
      .credit_avail_o (credit_avail),
      .trace_valid_o  (trace_valid_o),
      .trace_reg_o    (trace_reg_o),
      .trace_data_o   (trace_data_o)
   );

endmodule

`default_nettype wire

/* design/chip8_pkg.sv */
`default_nettype none

package chip8_pkg;

   localparam int ADDR_WIDTH = 12;
   localparam int DATA_WIDTH = 8;
   localparam int VREG_AW    = 4;
   localparam int CREDIT_W   = 3;

   localparam logic [VREG_AW-1:0]    VF_INDEX      = 4'hF;
   localparam logic [ADDR_WIDTH-1:0] PROGRAM_BASE  = 12'h200;
   localparam logic [CREDIT_W-1:0]   TRACE_CREDITS = 3'd4;

   // top nibble of the instruction
   typedef enum logic [3:0] {
      SYS      = 4'h0,
      JP       = 4'h1,
      CALL     = 4'h2,
      SE_BYTE  = 4'h3,
      SNE_BYTE = 4'h4,
      SE_REG   = 4'h5,
      LD_BYTE  = 4'h6,
      ADD_BYTE = 4'h7,
      ALU      = 4'h8,
      SNE_REG  = 4'h9,
      LD_I     = 4'hA,
      JP_V0    = 4'hB,
      RND      = 4'hC,
      DRW      = 4'hD,
      SKP      = 4'hE,
      LD_MISC  = 4'hF
   } opcode_e;

   typedef enum logic [2:0] {
      IDLE,
      FETCH_HI,
      FETCH_LO,
      READ,
      EXEC,
      FLAG
   } seq_state_e;

   // encoded as the 8XY_ low nibble
   typedef enum logic [3:0] {
      MOV  = 4'h0,
      OR   = 4'h1,
      AND  = 4'h2,
      XOR  = 4'h3,
      ADD  = 4'h4,
      SUB  = 4'h5,
      SHR  = 4'h6,
      SUBN = 4'h7,
      SHL  = 4'hE
   } alu_op_e;

endpackage

`default_nettype wire

/* design/program_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module program_ram
   import chip8_pkg::*;
(
   input  logic                  clk,
   input  logic                  load_we_i,
   input  logic [ADDR_WIDTH-1:0] load_addr_i,
   input  logic [DATA_WIDTH-1:0] load_data_i,
   input  logic [ADDR_WIDTH-1:0] rd_addr_i,
   output logic [DATA_WIDTH-1:0] rd_data_o
);

   logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

   always_ff @(posedge clk)
   begin
      if (load_we_i)
      begin
         mem[load_addr_i] <= load_data_i;
      end
      rd_data_o <= mem[rd_addr_i]; // one cycle read latency
   end

endmodule

`default_nettype wire

/* design/sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sequencer
   import chip8_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  run_i,
   output logic [ADDR_WIDTH-1:0] mem_addr_o,
   input  logic [DATA_WIDTH-1:0] mem_data_i,
   input  logic [DATA_WIDTH-1:0] vx_q_i,
   input  logic [DATA_WIDTH-1:0] vy_q_i,
   output logic [VREG_AW-1:0]    raddr_x_o,
   output logic [VREG_AW-1:0]    raddr_y_o,
   output logic                  reg_we_o,
   output logic [VREG_AW-1:0]    reg_waddr_o,
   output logic [DATA_WIDTH-1:0] reg_wdata_o,
   output alu_op_e               alu_op_o,
   input  logic [DATA_WIDTH-1:0] alu_result_i,
   input  logic                  alu_flag_i,
   input  logic                  credit_avail_i,
   output logic                  push_o,
   output logic                  halted_o
);

   seq_state_e            state_q;
   seq_state_e            state_d;
   logic [ADDR_WIDTH-1:0] pc_q;
   logic [DATA_WIDTH-1:0] ir_hi_q;
   logic [DATA_WIDTH-1:0] ir_lo_q;
   logic                  flag_q;
   logic                  halted_q;
   opcode_e               opcode;
   logic [ADDR_WIDTH-1:0] nnn;
   logic                  alu_valid;
   logic                  alu_has_flag;
   logic                  exec_we;
   logic                  skip_taken;
   logic                  self_jump;
   logic                  wants_write;
   logic                  write_go;

   assign opcode    = opcode_e'(ir_hi_q[7:4]);
   assign nnn       = {ir_hi_q[3:0], ir_lo_q};
   assign self_jump = (opcode == JP) && (nnn == pc_q - ADDR_WIDTH'(2)); // pc already advanced

   assign mem_addr_o = (state_q == FETCH_LO) ? pc_q + ADDR_WIDTH'(1) : pc_q;
   assign raddr_x_o  = (opcode == JP_V0) ? '0 : ir_hi_q[3:0];
   // low byte is still on the memory output during READ
   assign raddr_y_o  = (state_q == READ) ? mem_data_i[7:4] : ir_lo_q[7:4];

   always_comb
   begin
      case (ir_lo_q[3:0])
         4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hE:
         begin
            alu_op_o  = alu_op_e'(ir_lo_q[3:0]);
            alu_valid = 1'b1;
         end
         default:
         begin
            alu_op_o  = MOV;
            alu_valid = 1'b0; // unknown 8XY_ is a no-op
         end
      endcase
      alu_has_flag = alu_valid && (alu_op_o inside {ADD, SUB, SHR, SUBN, SHL});
   end

   always_comb
   begin
      exec_we    = 1'b0;
      skip_taken = 1'b0;
      case (opcode)
         LD_BYTE:  exec_we    = 1'b1;
         ADD_BYTE: exec_we    = 1'b1;
         ALU:      exec_we    = alu_valid;
         SE_BYTE:  skip_taken = (vx_q_i == ir_lo_q);
         SNE_BYTE: skip_taken = (vx_q_i != ir_lo_q);
         SE_REG:   skip_taken = (ir_lo_q[3:0] == 4'h0) && (vx_q_i == vy_q_i);
         SNE_REG:  skip_taken = (ir_lo_q[3:0] == 4'h0) && (vx_q_i != vy_q_i);
         default:  exec_we    = 1'b0;
      endcase
   end

   assign wants_write = ((state_q == EXEC) && exec_we) || (state_q == FLAG);
   assign write_go    = wants_write && credit_avail_i;
   assign reg_we_o    = write_go;
   assign push_o      = write_go;
   assign reg_waddr_o = (state_q == FLAG) ? VF_INDEX : ir_hi_q[3:0];

   always_comb
   begin
      if (state_q == FLAG)
         reg_wdata_o = {{(DATA_WIDTH-1){1'b0}}, flag_q};
      else if (opcode == LD_BYTE)
         reg_wdata_o = ir_lo_q;
      else if (opcode == ADD_BYTE)
         reg_wdata_o = vx_q_i + ir_lo_q; // wraps, VF untouched
      else
         reg_wdata_o = alu_result_i;
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:     if (run_i && !halted_q) state_d = FETCH_HI;
         FETCH_HI: state_d = FETCH_LO;
         FETCH_LO: state_d = READ;
         READ:     state_d = EXEC;
         EXEC:
         begin
            if (wants_write && !credit_avail_i)
               state_d = EXEC; // hold for credit
            else if ((opcode == ALU) && alu_has_flag)
               state_d = FLAG;
            else if (self_jump)
               state_d = IDLE;
            else
               state_d = FETCH_HI;
         end
         FLAG:     if (credit_avail_i) state_d = FETCH_HI;
         default:  state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q  <= IDLE;
         pc_q     <= PROGRAM_BASE;
         halted_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == FETCH_LO)
         begin
            pc_q <= pc_q + ADDR_WIDTH'(2);
         end
         else if (state_q == EXEC)
         begin
            if (opcode == JP)
            begin
               pc_q <= nnn;
               if (self_jump)
                  halted_q <= 1'b1;
            end
            else if (opcode == JP_V0)
               pc_q <= nnn + ADDR_WIDTH'(vx_q_i); // V0 on port x
            else if (skip_taken)
               pc_q <= pc_q + ADDR_WIDTH'(2);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == FETCH_LO)
         ir_hi_q <= mem_data_i;
      if (state_q == READ)
         ir_lo_q <= mem_data_i;
      if (state_q == EXEC)
         flag_q <= alu_flag_i; // VF value for a held FLAG
   end

   assign halted_o = halted_q;

endmodule

`default_nettype wire

/* design/trace_credit.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_credit
   import chip8_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  push_i,
   input  logic [VREG_AW-1:0]    push_reg_i,
   input  logic [DATA_WIDTH-1:0] push_data_i,
   input  logic                  trace_credit_i,
   output logic                  credit_avail_o,
   output logic                  trace_valid_o,
   output logic [VREG_AW-1:0]    trace_reg_o,
   output logic [DATA_WIDTH-1:0] trace_data_o
);

   logic [CREDIT_W-1:0] credits_q;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         credits_q     <= TRACE_CREDITS;
         trace_valid_o <= 1'b0;
      end
      else
      begin
         trace_valid_o <= push_i;
         case ({push_i, trace_credit_i})
            2'b10:   credits_q <= credits_q - CREDIT_W'(1);
            2'b01:   credits_q <= credits_q + CREDIT_W'(1);
            default: credits_q <= credits_q; // both or neither
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (push_i)
      begin
         trace_reg_o  <= push_reg_i;
         trace_data_o <= push_data_i;
      end
   end

   assign credit_avail_o = (credits_q != '0);

endmodule

`default_nettype wire

/* design/v_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module v_regfile
   import chip8_pkg::*;
(
   input  logic                  clk,
   input  logic                  we_i,
   input  logic [VREG_AW-1:0]    waddr_i,
   input  logic [DATA_WIDTH-1:0] wdata_i,
   input  logic [VREG_AW-1:0]    raddr_x_i,
   input  logic [VREG_AW-1:0]    raddr_y_i,
   output logic [DATA_WIDTH-1:0] vx_q_o,
   output logic [DATA_WIDTH-1:0] vy_q_o
);

   logic [DATA_WIDTH-1:0] regs [2**VREG_AW];

   always_ff @(posedge clk)
   begin
      if (we_i)
      begin
         regs[waddr_i] <= wdata_i;
      end
      // same-index write in this cycle still reads the old value
      vx_q_o <= regs[raddr_x_i];
      vy_q_o <= regs[raddr_y_i];
   end

endmodule

`default_nettype wire

/* testbench/tb_chip8.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_chip8
   import chip8_pkg::*;
();

   logic                  clk;
   logic                  arst_n;
   logic                  run;
   logic                  load_we;
   logic [ADDR_WIDTH-1:0] load_addr;
   logic [DATA_WIDTH-1:0] load_data;
   logic                  trace_credit = 1'b0;
   logic                  trace_valid;
   logic [VREG_AW-1:0]    trace_reg;
   logic [DATA_WIDTH-1:0] trace_data;
   logic                  halted;

   string      row_name [$];
   logic [7:0] row_kind [$]; // 8N = 8XYN, 70 = 7XNN, 3/4/5/90 = skips, B0 = BNNN, 60 = load burst
   logic [3:0] row_x [$];
   logic [3:0] row_y [$];
   logic [7:0] row_a [$];
   logic [7:0] row_b [$];
   int         row_hold [$];

   logic [11:0]           exp_q [$]; // {reg, data}
   logic [11:0]           got_q [$];
   logic [ADDR_WIDTH-1:0] wr_addr;
   logic [31:0]           rng = 32'h6e73_af47;
   logic [31:0]           gap_rng = 32'h6e73_af47;
   int                    beats_seen = 0;
   int                    credits_given = 0;
   int                    credit_wait = 0;
   bit                    hold_credit = 1'b0;

   chip8_core UUT (
      .clk            (clk),
      .arst_n_i       (arst_n),
      .run_i          (run),
      .load_we_i      (load_we),
      .load_addr_i    (load_addr),
      .load_data_i    (load_data),
      .trace_credit_i (trace_credit),
      .trace_valid_o  (trace_valid),
      .trace_reg_o    (trace_reg),
      .trace_data_o   (trace_data),
      .halted_o       (halted)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] v;
      v = s ^ (s << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function automatic logic [7:0] pick(input logic [7:0] v);
      if (v != 8'h00)
         return v;
      rng = xorshift(rng);
      return rng[7:0];
   endfunction

   // {flag, result} per the 8XY_ rules
   function automatic logic [8:0] alu_expect(input logic [3:0] op, input logic [7:0] vx,
                                             input logic [7:0] vy);
      case (op)
         4'h0:    return {1'b0, vy};
         4'h1:    return {1'b0, vx | vy};
         4'h2:    return {1'b0, vx & vy};
         4'h3:    return {1'b0, vx ^ vy};
         4'h4:    return {1'b0, vx} + {1'b0, vy};
         4'h5:    return {vx > vy, vx - vy};
         4'h6:    return {vy[0], vy >> 1};
         4'h7:    return {vy > vx, vy - vx};
         4'hE:    return {vy[7], vy << 1};
         default: return {1'b0, vx};
      endcase
   endfunction

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
         report_failure($sformatf("** Error: %s expected %0h actual %0h", name, expected,
                                  actual));
   endtask

   task automatic next_drive();
      @(posedge clk);
      #10;
   endtask

   task automatic write_byte(input logic [ADDR_WIDTH-1:0] addr, input logic [7:0] data);
      load_we   = 1'b1;
      load_addr = addr;
      load_data = data;
      next_drive();
      load_we   = 1'b0;
   endtask

   task automatic write_insn(input logic [7:0] hi, input logic [7:0] lo);
      write_byte(wr_addr, hi);
      write_byte(wr_addr + 12'd1, lo);
      wr_addr = wr_addr + 12'd2;
   endtask

   task automatic expect_beat(input logic [3:0] r, input logic [7:0] v);
      exp_q.push_back({r, v});
   endtask

   task automatic set_reg(input logic [3:0] r, input logic [7:0] v);
      write_insn({4'h6, r}, v);
      expect_beat(r, v);
   endtask

   task automatic put_halt();
      write_insn({4'h1, wr_addr[11:8]}, wr_addr[7:0]); // jump to itself
   endtask

   task automatic build_program(input int i);
      logic [3:0] x;
      logic [3:0] y;
      logic [3:0] hi;
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] v;
      logic [8:0] r;
      logic       taken;
      x  = row_x[i];
      y  = row_y[i];
      hi = row_kind[i][7:4];
      a  = pick(row_a[i]);
      b  = pick(row_b[i]);
      wr_addr = PROGRAM_BASE;
      exp_q.delete();
      case (hi)
         4'h6:
         begin
            v = a;
            for (int k = 1; k <= 8; k++)
            begin
               set_reg(k[3:0], v);
               v = v + b;
            end
         end
         4'h7:
         begin
            set_reg(x, a);
            write_insn({4'h7, x}, b);
            expect_beat(x, a + b); // no VF beat on overflow
         end
         4'h8:
         begin
            set_reg(x, a);
            set_reg(y, b);
            write_insn({4'h8, x}, {y, row_kind[i][3:0]});
            r = alu_expect(row_kind[i][3:0], a, b);
            expect_beat(x, r[7:0]);
            if (row_kind[i][3:0] inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hE})
               expect_beat(VF_INDEX, {7'd0, r[8]});
         end
         4'hB:
         begin
            set_reg(4'h0, a);
            write_insn(8'hB2, 8'h40);
            write_insn(8'h6D, 8'h01); // jumped over
            put_halt();
            wr_addr = 12'h240 + a;
            set_reg(4'hD, 8'h03);
         end
         default:
         begin
            set_reg(x, a);
            set_reg(y, b);
            if (hi == 4'h3 || hi == 4'h4)
               write_insn({hi, x}, b);
            else
               write_insn({hi, x}, {y, 4'h0});
            taken = (a == b) ^ (hi == 4'h4 || hi == 4'h9);
            write_insn(8'h6D, 8'h01); // VD is the marker
            if (!taken)
               expect_beat(4'hD, 8'h01);
            set_reg(4'hD, 8'h02);
         end
      endcase
      put_halt();
   endtask

   task automatic wait_halt(input string name);
      int n;
      n = 0;
      while (!halted)
      begin
         @(negedge clk);
         n++;
         if (n > 500)
            report_failure({"timeout: halted_o never rose in ", name});
      end
   endtask

   task automatic drain_credits(input string name);
      int n;
      n = 0;
      while (beats_seen != credits_given)
      begin
         @(negedge clk);
         n++;
         if (n > 100)
            report_failure({"timeout: credits were not all returned in ", name});
      end
   endtask

   task automatic run_row(input int i);
      next_drive();
      arst_n = 1'b0;
      repeat (2) next_drive();
      arst_n = 1'b1;
      got_q.delete();
      build_program(i);
      check_value({row_name[i], " halted after reset"}, 0, halted);
      hold_credit = (row_hold[i] > 0);
      run = 1'b1;
      if (hold_credit)
      begin
         repeat (row_hold[i]) @(negedge clk);
         check_value({row_name[i], " beats while held"}, TRACE_CREDITS, got_q.size());
         hold_credit = 1'b0;
      end
      wait_halt(row_name[i]);
      next_drive();
      run = 1'b0;
      repeat (20) @(negedge clk); // quiet window after halt
      check_value({row_name[i], " halted"}, 1, halted);
      check_value({row_name[i], " beat count"}, exp_q.size(), got_q.size());
      foreach (exp_q[k])
         check_value($sformatf("%s beat %0d", row_name[i], k), exp_q[k], got_q[k]);
      drain_credits(row_name[i]);
   endtask

   task automatic add_row(input string name, input logic [7:0] kind, input logic [3:0] x,
                          input logic [3:0] y, input logic [7:0] a, input logic [7:0] b,
                          input int hold);
      row_name.push_back(name);
      row_kind.push_back(kind);
      row_x.push_back(x);
      row_y.push_back(y);
      row_a.push_back(a);
      row_b.push_back(b);
      row_hold.push_back(hold);
   endtask

   always @(negedge clk)
   begin
      if (trace_valid)
      begin
         got_q.push_back({trace_reg, trace_data});
         beats_seen = beats_seen + 1;
         if (beats_seen - credits_given > TRACE_CREDITS)
            report_failure("more trace beats appeared than credits were available");
      end
   end

   // credit returner with a random gap of 0 to 5 cycles
   always
   begin
      next_drive();
      trace_credit = 1'b0;
      if (credit_wait > 0)
         credit_wait = credit_wait - 1;
      else if ((beats_seen > credits_given) && !hold_credit)
      begin
         trace_credit  = 1'b1;
         credits_given = credits_given + 1;
         gap_rng       = xorshift(gap_rng);
         credit_wait   = gap_rng % 6;
      end
   end

   initial
   begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      run       = 1'b0;
      load_we   = 1'b0;
      load_addr = '0;
      load_data = '0;
      add_row("burst_held",   8'h60, 4'h0, 4'h0, 8'h00, 8'h00, 40);
      add_row("burst",        8'h60, 4'h0, 4'h0, 8'h11, 8'h23, 0);
      add_row("mov",          8'h80, 4'h1, 4'h2, 8'h00, 8'h00, 0);
      add_row("or",           8'h81, 4'h3, 4'h4, 8'h00, 8'h00, 0);
      add_row("and",          8'h82, 4'h5, 4'h6, 8'h00, 8'h00, 0);
      add_row("xor",          8'h83, 4'h7, 4'h8, 8'h00, 8'h00, 0);
      add_row("add_carry",    8'h84, 4'h1, 4'h2, 8'hF0, 8'h20, 0);
      add_row("add",          8'h84, 4'h9, 4'hA, 8'h00, 8'h00, 0);
      add_row("sub_gt",       8'h85, 4'h1, 4'h2, 8'h50, 8'h20, 0);
      add_row("sub_eq",       8'h85, 4'hB, 4'hC, 8'h33, 8'h33, 0);
      add_row("sub_lt",       8'h85, 4'h2, 4'h1, 8'h10, 8'h80, 0);
      add_row("shr",          8'h86, 4'h3, 4'h4, 8'h00, 8'h00, 0);
      add_row("subn_gt",      8'h87, 4'h5, 4'h6, 8'h20, 8'h50, 0);
      add_row("subn_eq",      8'h87, 4'h6, 4'h5, 8'h44, 8'h44, 0);
      add_row("shl",          8'h8E, 4'h7, 4'h8, 8'h00, 8'h81, 0);
      add_row("add_byte_ovf", 8'h70, 4'h4, 4'h0, 8'hF0, 8'h30, 0);
      add_row("add_byte",     8'h70, 4'hE, 4'h0, 8'h00, 8'h00, 0);
      add_row("se_byte_hit",  8'h30, 4'h1, 4'h2, 8'h5A, 8'h5A, 0);
      add_row("se_byte",      8'h30, 4'h3, 4'h4, 8'h00, 8'h00, 0);
      add_row("sne_byte_eq",  8'h40, 4'h5, 4'h6, 8'h5A, 8'h5A, 0);
      add_row("sne_byte",     8'h40, 4'h7, 4'h8, 8'h00, 8'h00, 0);
      add_row("se_reg_hit",   8'h50, 4'h9, 4'hA, 8'h77, 8'h77, 0);
      add_row("se_reg",       8'h50, 4'hB, 4'hC, 8'h12, 8'h34, 0);
      add_row("sne_reg",      8'h90, 4'h1, 4'h2, 8'h12, 8'h34, 0);
      add_row("sne_reg_eq",   8'h90, 4'h3, 4'h4, 8'h66, 8'h66, 0);
      add_row("jp_v0",        8'hB0, 4'h0, 4'h0, 8'h00, 8'h00, 0);
      next_drive();
      for (int i = 0; i < row_name.size(); i++)
         run_row(i);
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire
